// File: flist.f
+incdir+.
ttc_pkg.sv
ttc_reg_file.sv
ttc_ctrl_fsm.sv
ttc_counter.sv
ttc_interrupt.sv
ttc_top.sv
tb_ttc.sv

// File: tb_ttc.sv
`timescale 1ns/1ps
`default_nettype none

`include "ttc_defines.svh"

module tb_ttc
  import ttc_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_ROWS     = 64;

  // Row operations
  localparam int OP_WR       = 0;  // Register write
  localparam int OP_RD       = 1;  // Read and compare
  localparam int OP_RD_SAME  = 2;  // Read and compare with previous read
  localparam int OP_RD_FLUSH = 3;  // Read with value ignored
  localparam int OP_WAIT     = 4;  // Idle cycles
  localparam int OP_WAIT_IRQ = 5;  // Bounded wait for interrupt
  localparam int OP_IRQ      = 6;  // Check interrupt level

  logic      pclk15;
  logic      n_p_reset15;
  logic      wr_strobe;
  logic      rd_strobe;
  reg_addr_t addr;
  reg_data_t wdata;
  reg_data_t rdata;
  logic      rd_valid;
  logic      interrupt;

  // Stimulus table
  int        row_op   [MAX_ROWS];
  reg_addr_t row_addr [MAX_ROWS];
  reg_data_t row_data [MAX_ROWS];
  reg_data_t row_exp  [MAX_ROWS];
  int        num_rows      = 0;
  int        cycle_count   = 0;
  int        timeout_limit = 0;  // Zero until the table is built

  ttc_top u_dut (
    .pclk15      (pclk15),
    .n_p_reset15 (n_p_reset15),
    .wr_strobe   (wr_strobe),
    .rd_strobe   (rd_strobe),
    .addr        (addr),
    .wdata       (wdata),
    .rdata       (rdata),
    .rd_valid    (rd_valid),
    .interrupt   (interrupt)
  );

  initial
  begin
    pclk15 = 1'b0;
    forever #(CLK_PERIOD/2) pclk15 = ~pclk15;
  end

  // Run length guard
  always @(posedge pclk15)
  begin
    cycle_count = cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit)
    begin
      $display("Run timed out after %0d clock cycles", cycle_count);
      stop_on_error();
    end
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic stop_on_error();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_data(input reg_data_t actual, input reg_data_t expected,
                            input string what);
    if (actual !== expected)
    begin
      $display("FAIL %0t ns: %s read %h, expected %h", $time, what, actual, expected);
      stop_on_error();
    end
  endtask

  task automatic check_intr(input intr_vec_t actual, input intr_vec_t expected,
                            input string what);
    if (actual !== expected)
    begin
      $display("FAIL %0t ns: %s flags %b, expected %b", $time, what, actual, expected);
      stop_on_error();
    end
  endtask

  task automatic check_irq(input logic actual, input logic expected, input string what);
    if (actual !== expected)
    begin
      $display("FAIL %0t ns: %s interrupt %b, expected %b", $time, what, actual, expected);
      stop_on_error();
    end
  endtask

  task automatic check_valid(input logic actual, input logic expected, input string what);
    if (actual !== expected)
    begin
      $display("FAIL %0t ns: %s rd_valid %b, expected %b", $time, what, actual, expected);
      stop_on_error();
    end
  endtask

  task automatic add_row(input int op, input reg_addr_t a, input reg_data_t d,
                         input reg_data_t e);
    row_op[num_rows]   = op;
    row_addr[num_rows] = a;
    row_data[num_rows] = d;
    row_exp[num_rows]  = e;
    num_rows           = num_rows + 1;
  endtask

  task automatic bus_write(input reg_addr_t a, input reg_data_t d);
    @(negedge pclk15);
    wr_strobe = 1'b1;
    addr      = a;
    wdata     = d;
    @(negedge pclk15);
    wr_strobe = 1'b0;  // Single cycle strobe
  endtask

  // Strobe for one cycle with data and valid one cycle later
  task automatic bus_read(input reg_addr_t a, output reg_data_t d);
    @(negedge pclk15);
    check_valid(rd_valid, 1'b0, "idle before read");
    rd_strobe = 1'b1;
    addr      = a;
    @(negedge pclk15);
    rd_strobe = 1'b0;
    check_valid(rd_valid, 1'b1, "one cycle after strobe");
    d = rdata;
  endtask

  task automatic wait_for_irq(input int limit);
    int n;
    n = 0;
    while (interrupt !== 1'b1 && n < limit)
    begin
      @(negedge pclk15);
      n = n + 1;
    end
    if (interrupt !== 1'b1)
    begin
      $display("Interrupt did not rise within %0d cycles at %0t ns", limit, $time);
      stop_on_error();
    end
  endtask

  // --------------------------------------------------
  // Table and main loop
  // --------------------------------------------------
  initial
  begin
    reg_data_t   got;
    reg_data_t   last_read;
    reg_data_t   m1;
    reg_data_t   m2;
    reg_data_t   m3;
    int          wait_sum;

    wr_strobe   = 1'b0;
    rd_strobe   = 1'b0;
    addr        = '0;
    wdata       = '0;
    n_p_reset15 = 1'b0;
    last_read   = '0;

    void'($urandom(32'h25d62eca));  // Seed once
    m1 = reg_data_t'($urandom % 9);  // Below interval of 9
    m2 = reg_data_t'($urandom % 9);
    m3 = reg_data_t'($urandom % 9);

    // Read back and unused addresses
    add_row(OP_WR, `TTC_ADDR_INTERVAL, 16'h1234, 16'h0);
    add_row(OP_RD, `TTC_ADDR_INTERVAL, 16'h0, 16'h1234);
    add_row(OP_WR, `TTC_ADDR_MATCH1, 16'habcd, 16'h0);
    add_row(OP_RD, `TTC_ADDR_MATCH1, 16'h0, 16'habcd);
    add_row(OP_WR, `TTC_ADDR_MATCH2, 16'h5a5a, 16'h0);
    add_row(OP_RD, `TTC_ADDR_MATCH2, 16'h0, 16'h5a5a);
    add_row(OP_WR, `TTC_ADDR_MATCH3, 16'hc3c3, 16'h0);
    add_row(OP_RD, `TTC_ADDR_MATCH3, 16'h0, 16'hc3c3);
    add_row(OP_WR, `TTC_ADDR_INTR_EN, 16'h0015, 16'h0);
    add_row(OP_RD, `TTC_ADDR_INTR_EN, 16'h0, 16'h0015);
    add_row(OP_WR, `TTC_ADDR_CTRL, 16'h0016, 16'h0);  // Restart bit not kept
    add_row(OP_RD, `TTC_ADDR_CTRL, 16'h0, 16'h0006);
    add_row(OP_RD, `TTC_ADDR_COUNT, 16'h0, 16'h0);
    add_row(OP_RD, 4'h8, 16'h0, 16'h0);
    add_row(OP_RD, 4'hf, 16'h0, 16'h0);
    // Interval mode and clear on read
    add_row(OP_WR, `TTC_ADDR_INTERVAL, 16'd9, 16'h0);
    add_row(OP_WR, `TTC_ADDR_INTR_EN, 16'h0001, 16'h0);
    add_row(OP_WR, `TTC_ADDR_CTRL, 16'h0013, 16'h0);
    add_row(OP_RD, `TTC_ADDR_CTRL, 16'h0, 16'h0003);
    add_row(OP_WAIT_IRQ, 4'h0, 16'd20, 16'h0);
    add_row(OP_RD, `TTC_ADDR_INTR_STAT, 16'h0, 16'h0001);
    add_row(OP_RD, `TTC_ADDR_INTR_STAT, 16'h0, 16'h0000);
    add_row(OP_IRQ, 4'h0, 16'h0, 16'h0);
    // Masking with only match1 enabled
    add_row(OP_WR, `TTC_ADDR_CTRL, 16'h0000, 16'h0);
    add_row(OP_WR, `TTC_ADDR_INTR_EN, 16'h0002, 16'h0);
    add_row(OP_WAIT, 4'h0, 16'd4, 16'h0);
    add_row(OP_RD_FLUSH, `TTC_ADDR_INTR_STAT, 16'h0, 16'h0);
    add_row(OP_RD, `TTC_ADDR_INTR_STAT, 16'h0, 16'h0000);
    add_row(OP_WR, `TTC_ADDR_MATCH1, m1, 16'h0);
    add_row(OP_WR, `TTC_ADDR_MATCH2, m2, 16'h0);
    add_row(OP_WR, `TTC_ADDR_MATCH3, m3, 16'h0);
    add_row(OP_WR, `TTC_ADDR_CTRL, 16'h0017, 16'h0);
    add_row(OP_WAIT, 4'h0, 16'd20, 16'h0);
    add_row(OP_RD, `TTC_ADDR_INTR_STAT, 16'h0, 16'h0002);
    // Stop holds the count and restart zeroes it
    add_row(OP_WR, `TTC_ADDR_CTRL, 16'h0006, 16'h0);
    add_row(OP_WAIT, 4'h0, 16'd4, 16'h0);
    add_row(OP_RD_FLUSH, `TTC_ADDR_COUNT, 16'h0, 16'h0);
    add_row(OP_RD_SAME, `TTC_ADDR_COUNT, 16'h0, 16'h0);
    add_row(OP_WR, `TTC_ADDR_CTRL, 16'h0010, 16'h0);
    add_row(OP_WAIT, 4'h0, 16'd2, 16'h0);
    add_row(OP_RD, `TTC_ADDR_COUNT, 16'h0, 16'h0);
    add_row(OP_RD_FLUSH, `TTC_ADDR_INTR_STAT, 16'h0, 16'h0);
    add_row(OP_RD, `TTC_ADDR_INTR_STAT, 16'h0, 16'h0000);
    add_row(OP_IRQ, 4'h0, 16'h0, 16'h0);
    // Free running overflow
    add_row(OP_WR, `TTC_ADDR_INTR_EN, 16'h0030, 16'h0);
    add_row(OP_WR, `TTC_ADDR_CTRL, 16'h0011, 16'h0);
    add_row(OP_WAIT, 4'h0, 16'd65530, 16'h0);  // Just short of the wrap
    add_row(OP_RD, `TTC_ADDR_INTR_STAT, 16'h0, 16'h0000);
    add_row(OP_WAIT_IRQ, 4'h0, 16'd20, 16'h0);
    add_row(OP_RD, `TTC_ADDR_INTR_STAT, 16'h0, 16'h0010);
    add_row(OP_RD, `TTC_ADDR_INTR_STAT, 16'h0, 16'h0000);
    add_row(OP_IRQ, 4'h0, 16'h0, 16'h0);

    wait_sum = 0;
    for (int i = 0; i < num_rows; i++)
      if (row_op[i] == OP_WAIT || row_op[i] == OP_WAIT_IRQ)
        wait_sum = wait_sum + int'(row_data[i]);
    timeout_limit = RESET_CYCLES + wait_sum + 20 * num_rows;

    repeat (RESET_CYCLES) @(negedge pclk15);
    n_p_reset15 = 1'b1;

    for (int i = 0; i < num_rows; i++)
    begin
      case (row_op[i])
        OP_WR:
          bus_write(row_addr[i], row_data[i]);
        OP_RD:
        begin
          bus_read(row_addr[i], got);
          if (row_addr[i] == `TTC_ADDR_INTR_STAT)
            check_intr(intr_vec_t'(got), intr_vec_t'(row_exp[i]),
                       $sformatf("row %0d status", i));
          else
            check_data(got, row_exp[i], $sformatf("row %0d addr %h", i, row_addr[i]));
          last_read = got;
        end
        OP_RD_SAME:
        begin
          bus_read(row_addr[i], got);
          check_data(got, last_read, $sformatf("row %0d repeated read", i));
          last_read = got;
        end
        OP_RD_FLUSH:
        begin
          bus_read(row_addr[i], got);
          last_read = got;  // Reference for a following repeat
        end
        OP_WAIT:
          repeat (int'(row_data[i])) @(negedge pclk15);
        OP_WAIT_IRQ:
          wait_for_irq(int'(row_data[i]));
        OP_IRQ:
        begin
          @(negedge pclk15);
          check_irq(interrupt, row_exp[i][0], $sformatf("row %0d", i));
        end
        default:
        begin
          $display("Table row %0d holds an unknown operation", i);
          stop_on_error();
        end
      endcase
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: ttc_counter.sv
`timescale 1ns/1ps
`default_nettype none

module ttc_counter
  import ttc_pkg::*;
(
  input  wire         pclk15,
  input  wire         n_p_reset15,
  input  wire         count_en,        // From control FSM
  input  wire         count_clear,     // From control FSM
  input  wire         interval_mode,   // Wrap at interval value
  input  wire         match_mode,      // Compare enable
  input  cnt_t        interval_value,
  input  cnt_t        match1_value,
  input  cnt_t        match2_value,
  input  cnt_t        match3_value,
  output cnt_t        count_value,
  output logic        interval_intr,   // Interval reached
  output logic [2:0]  match_intr,      // Match 1..3
  output logic        overflow_intr    // Free running wrap
);

  logic       at_interval;  // Counter equals interval
  logic       at_top;       // Counter all ones
  logic [2:0] match_hit;

  // --------------------------------------------------
  // Compare logic
  // --------------------------------------------------
  assign at_interval = (count_value == interval_value);
  assign at_top      = &count_value;

  assign match_hit[0] = (count_value == match1_value);
  assign match_hit[1] = (count_value == match2_value);
  assign match_hit[2] = (count_value == match3_value);

  // --------------------------------------------------
  // Counter
  // --------------------------------------------------
  always_ff @(posedge pclk15 or negedge n_p_reset15)
  begin
    if (!n_p_reset15)
      count_value <= '0;
    else if (count_clear)
      count_value <= '0;
    else if (count_en)
    begin
      if (interval_mode && at_interval)
        count_value <= '0;              // Interval wrap
      else
        count_value <= count_value + 1'b1;  // Free mode wraps naturally
    end
  end

  // Event outputs, one registered cycle each
  always_ff @(posedge pclk15 or negedge n_p_reset15)
  begin
    if (!n_p_reset15)
    begin
      interval_intr <= 1'b0;
      match_intr    <= 3'b000;
      overflow_intr <= 1'b0;
    end
    else
    begin
      // Wrap events only when a wrap actually happens
      interval_intr <= count_en && !count_clear && interval_mode && at_interval;
      overflow_intr <= count_en && !count_clear && !interval_mode && at_top;
      // Level compare, edge found downstream
      match_intr    <= match_mode ? match_hit : 3'b000;
    end
  end

endmodule

`default_nettype wire

// File: ttc_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module ttc_ctrl_fsm
  import ttc_pkg::*;
(
  input  wire   pclk15,
  input  wire   n_p_reset15,
  input  wire   enable,       // Control register enable bit
  input  wire   restart_req,  // One cycle request
  output logic  count_en,     // Counter increments
  output logic  count_clear   // Counter zeroes
);

  ctrl_state_t state;
  ctrl_state_t next_state;

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb
  begin
    next_state = state;
    case (state)
      ST_STOPPED:
      begin
        if (restart_req)
          next_state = ST_RESTART;
        else if (enable)
          next_state = ST_RUNNING;
      end
      ST_RUNNING:
      begin
        if (restart_req)
          next_state = ST_RESTART;
        else if (!enable)
          next_state = ST_STOPPED;
      end
      ST_RESTART:
        next_state = enable ? ST_RUNNING : ST_STOPPED;  // Single cycle
      default:
        next_state = ST_STOPPED;  // Unused encoding
    endcase
  end

  // State and registered outputs, clear and count never overlap
  always_ff @(posedge pclk15 or negedge n_p_reset15)
  begin
    if (!n_p_reset15)
    begin
      state       <= ST_STOPPED;
      count_en    <= 1'b0;
      count_clear <= 1'b0;
    end
    else
    begin
      state       <= next_state;
      count_en    <= (next_state == ST_RUNNING);
      count_clear <= (next_state == ST_RESTART);
    end
  end

endmodule

`default_nettype wire

// File: ttc_defines.svh
`ifndef TTC_DEFINES_SVH
`define TTC_DEFINES_SVH

// Datapath widths
`define TTC_CNT_WIDTH      16
`define TTC_ADDR_WIDTH     4
`define TTC_NUM_INTR       6

// Register map, unlisted addresses read as zero
`define TTC_ADDR_CTRL      4'h0
`define TTC_ADDR_COUNT     4'h1   // Read only
`define TTC_ADDR_INTERVAL  4'h2
`define TTC_ADDR_MATCH1    4'h3
`define TTC_ADDR_MATCH2    4'h4
`define TTC_ADDR_MATCH3    4'h5
`define TTC_ADDR_INTR_STAT 4'h6   // Read only, clears on read
`define TTC_ADDR_INTR_EN   4'h7

// Control register bits
`define TTC_CTRL_ENABLE    0
`define TTC_CTRL_INTERVAL  1
`define TTC_CTRL_MATCH     2
`define TTC_CTRL_RESTART   4      // Self clearing request

`endif

// File: ttc_interrupt.sv
`timescale 1ns/1ps
`default_nettype none

module ttc_interrupt
  import ttc_pkg::*;
(
  input  wire         pclk15,
  input  wire         n_p_reset15,
  input  intr_vec_t   wdata,            // Enable bits from the write data
  input  wire         intr_en_sel,      // Enable register write
  input  wire         clear_interrupt,  // Status register read
  input  wire         interval_intr,
  input  wire  [2:0]  match_intr,
  input  wire         overflow_intr,
  output logic        interrupt,        // Combined line
  output intr_vec_t   intr_reg,         // Sticky flags
  output intr_vec_t   intr_en           // Mask register
);

  intr_vec_t intr_detect;  // Raw sources
  intr_vec_t sync_reg;     // Previous source levels
  intr_vec_t edge_reg;     // Rising edges, one cycle
  logic      intr_set;     // Edge seen last cycle

  // Bit 5 reserved, tied low
  assign intr_detect = {1'b0, overflow_intr, match_intr, interval_intr};

  assign interrupt = |intr_reg;

  // --------------------------------------------------
  // Edge detect and sticky flags
  // --------------------------------------------------
  always_ff @(posedge pclk15 or negedge n_p_reset15)
  begin
    if (!n_p_reset15)
    begin
      sync_reg <= '0;
      edge_reg <= '0;
      intr_set <= 1'b0;
      intr_reg <= '0;
    end
    else
    begin
      sync_reg <= intr_detect;
      edge_reg <= ~sync_reg & intr_detect;  // Rising edge
      intr_set <= |edge_reg;                // Guards a pending event

      // Clear keeps the events arriving this cycle
      if (clear_interrupt && !intr_set)
        intr_reg <= edge_reg & intr_en;
      else
        intr_reg <= intr_reg | (edge_reg & intr_en);
    end
  end

  // --------------------------------------------------
  // Enable register
  // --------------------------------------------------
  always_ff @(posedge pclk15 or negedge n_p_reset15)
  begin
    if (!n_p_reset15)
      intr_en <= '0;
    else if (intr_en_sel)
      intr_en <= wdata;
  end

endmodule

`default_nettype wire

// File: ttc_pkg.sv
`default_nettype none

`include "ttc_defines.svh"

package ttc_pkg;

  // --------------------------------------------------
  // Datapath types
  // --------------------------------------------------
  typedef logic [`TTC_CNT_WIDTH-1:0]  cnt_t;       // Counter value
  typedef logic [`TTC_CNT_WIDTH-1:0]  reg_data_t;  // Register word
  typedef logic [`TTC_ADDR_WIDTH-1:0] reg_addr_t;  // Register address

  // Interrupt sources
  // bit 0 interval, bits 1..3 match1..3, bit 4 overflow, bit 5 reserved
  typedef logic [`TTC_NUM_INTR-1:0]   intr_vec_t;

  // --------------------------------------------------
  // Control FSM states
  // --------------------------------------------------
  typedef enum logic [1:0] {
    ST_STOPPED = 2'd0,  // Counter held
    ST_RESTART = 2'd1,  // One cycle clear
    ST_RUNNING = 2'd2   // Counting
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: ttc_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "ttc_defines.svh"

module ttc_reg_file
  import ttc_pkg::*;
(
  input  wire        pclk15,
  input  wire        n_p_reset15,
  input  wire        wr_strobe,        // Single cycle write
  input  wire        rd_strobe,        // Single cycle read
  input  reg_addr_t  addr,
  input  reg_data_t  wdata,
  input  cnt_t       count_value,      // Live counter for reads
  input  intr_vec_t  intr_reg,         // Sticky flags
  input  intr_vec_t  intr_en,          // Interrupt mask
  output reg_data_t  rdata,
  output logic       rd_valid,
  output logic       enable,
  output logic       interval_mode,
  output logic       match_mode,
  output logic       restart_req,      // One cycle pulse
  output cnt_t       interval_value,
  output cnt_t       match1_value,
  output cnt_t       match2_value,
  output cnt_t       match3_value,
  output logic       intr_en_sel,      // Enable register write
  output logic       clear_interrupt   // Status read clears flags
);

  reg_data_t rd_mux;  // Read data before the register
  logic      ctrl_wr;

  // --------------------------------------------------
  // Strobe decode
  // --------------------------------------------------
  assign ctrl_wr         = wr_strobe && (addr == `TTC_ADDR_CTRL);
  assign intr_en_sel     = wr_strobe && (addr == `TTC_ADDR_INTR_EN);
  assign clear_interrupt = rd_strobe && (addr == `TTC_ADDR_INTR_STAT);

  // --------------------------------------------------
  // Writable registers
  // --------------------------------------------------
  always_ff @(posedge pclk15 or negedge n_p_reset15)
  begin
    if (!n_p_reset15)
    begin
      enable         <= 1'b0;
      interval_mode  <= 1'b0;
      match_mode     <= 1'b0;
      restart_req    <= 1'b0;
      interval_value <= '0;
      match1_value   <= '0;
      match2_value   <= '0;
      match3_value   <= '0;
    end
    else
    begin
      // Restart bit is never stored, only pulsed
      restart_req <= ctrl_wr && wdata[`TTC_CTRL_RESTART];
      if (ctrl_wr)
      begin
        enable        <= wdata[`TTC_CTRL_ENABLE];
        interval_mode <= wdata[`TTC_CTRL_INTERVAL];
        match_mode    <= wdata[`TTC_CTRL_MATCH];
      end
      if (wr_strobe)
      begin
        case (addr)
          `TTC_ADDR_INTERVAL: interval_value <= wdata;
          `TTC_ADDR_MATCH1:   match1_value   <= wdata;
          `TTC_ADDR_MATCH2:   match2_value   <= wdata;
          `TTC_ADDR_MATCH3:   match3_value   <= wdata;
          default:            ;  // Control handled above, rest read only
        endcase
      end
    end
  end

  // --------------------------------------------------
  // Read path
  // --------------------------------------------------
  always_comb
  begin
    rd_mux = '0;  // Unused addresses
    case (addr)
      `TTC_ADDR_CTRL:
      begin
        rd_mux[`TTC_CTRL_ENABLE]   = enable;
        rd_mux[`TTC_CTRL_INTERVAL] = interval_mode;
        rd_mux[`TTC_CTRL_MATCH]    = match_mode;
      end
      `TTC_ADDR_COUNT:     rd_mux = count_value;
      `TTC_ADDR_INTERVAL:  rd_mux = interval_value;
      `TTC_ADDR_MATCH1:    rd_mux = match1_value;
      `TTC_ADDR_MATCH2:    rd_mux = match2_value;
      `TTC_ADDR_MATCH3:    rd_mux = match3_value;
      `TTC_ADDR_INTR_STAT: rd_mux = {{(`TTC_CNT_WIDTH-`TTC_NUM_INTR){1'b0}}, intr_reg};
      `TTC_ADDR_INTR_EN:   rd_mux = {{(`TTC_CNT_WIDTH-`TTC_NUM_INTR){1'b0}}, intr_en};
      default:             rd_mux = '0;
    endcase
  end

  // Data appears one cycle after the strobe
  always_ff @(posedge pclk15 or negedge n_p_reset15)
  begin
    if (!n_p_reset15)
    begin
      rdata    <= '0;
      rd_valid <= 1'b0;
    end
    else
    begin
      rd_valid <= rd_strobe;
      if (rd_strobe)
        rdata <= rd_mux;  // Hold between reads
    end
  end

endmodule

`default_nettype wire

// File: ttc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ttc_defines.svh"

module ttc_top
  import ttc_pkg::*;
(
  input  wire        pclk15,
  input  wire        n_p_reset15,
  input  wire        wr_strobe,
  input  wire        rd_strobe,
  input  reg_addr_t  addr,
  input  reg_data_t  wdata,
  output reg_data_t  rdata,
  output logic       rd_valid,
  output logic       interrupt
);

  // Register file outputs
  logic       enable;
  logic       interval_mode;
  logic       match_mode;
  logic       restart_req;
  cnt_t       interval_value;
  cnt_t       match1_value;
  cnt_t       match2_value;
  cnt_t       match3_value;
  logic       intr_en_sel;
  logic       clear_interrupt;

  // FSM to counter
  logic       count_en;
  logic       count_clear;

  // Counter events
  cnt_t       count_value;
  logic       interval_intr;
  logic [2:0] match_intr;
  logic       overflow_intr;

  // Interrupt block state for reads
  intr_vec_t  intr_reg;
  intr_vec_t  intr_en;

  // --------------------------------------------------
  // Blocks
  // --------------------------------------------------
  ttc_reg_file u_reg_file (
    .pclk15          (pclk15),
    .n_p_reset15     (n_p_reset15),
    .wr_strobe       (wr_strobe),
    .rd_strobe       (rd_strobe),
    .addr            (addr),
    .wdata           (wdata),
    .count_value     (count_value),
    .intr_reg        (intr_reg),
    .intr_en         (intr_en),
    .rdata           (rdata),
    .rd_valid        (rd_valid),
    .enable          (enable),
    .interval_mode   (interval_mode),
    .match_mode      (match_mode),
    .restart_req     (restart_req),
    .interval_value  (interval_value),
    .match1_value    (match1_value),
    .match2_value    (match2_value),
    .match3_value    (match3_value),
    .intr_en_sel     (intr_en_sel),
    .clear_interrupt (clear_interrupt)
  );

  ttc_ctrl_fsm u_ctrl_fsm (
    .pclk15      (pclk15),
    .n_p_reset15 (n_p_reset15),
    .enable      (enable),
    .restart_req (restart_req),
    .count_en    (count_en),
    .count_clear (count_clear)
  );

  ttc_counter u_counter (
    .pclk15         (pclk15),
    .n_p_reset15    (n_p_reset15),
    .count_en       (count_en),
    .count_clear    (count_clear),
    .interval_mode  (interval_mode),
    .match_mode     (match_mode),
    .interval_value (interval_value),
    .match1_value   (match1_value),
    .match2_value   (match2_value),
    .match3_value   (match3_value),
    .count_value    (count_value),
    .interval_intr  (interval_intr),
    .match_intr     (match_intr),
    .overflow_intr  (overflow_intr)
  );

  // Low bits of the write data carry the enable mask
  ttc_interrupt u_interrupt (
    .pclk15          (pclk15),
    .n_p_reset15     (n_p_reset15),
    .wdata           (wdata[`TTC_NUM_INTR-1:0]),
    .intr_en_sel     (intr_en_sel),
    .clear_interrupt (clear_interrupt),
    .interval_intr   (interval_intr),
    .match_intr      (match_intr),
    .overflow_intr   (overflow_intr),
    .interrupt       (interrupt),
    .intr_reg        (intr_reg),
    .intr_en         (intr_en)
  );

endmodule

`default_nettype wire
